//--- build.f
logic/trim_pkg.sv
logic/trim_chop.sv
logic/trim_drain.sv
logic/trim_sequencer.sv
logic/trim_top.sv
verification/trim_assert.sv
verification/trim_tb.sv

//--- logic/trim_chop.sv
module trim_chop (
  input  logic            clock,
  input  logic            rst_n_i,

  // window and limit from the sequencer
  input  logic            window_i,
  input  trim_pkg::len_t  len_i,

  // source side
  input  logic            src_valid_i,
  output logic            src_ready_o,
  input  logic            src_last_i,
  input  trim_pkg::data_t src_data_i,

  // sink side
  output logic            snk_valid_o,
  input  logic            snk_ready_i,
  output logic            snk_last_o,
  output trim_pkg::data_t snk_data_o,

  // per-packet results
  output logic            final_o,
  output logic            chopped_o,
  output trim_pkg::len_t  kept_o
);

  // source handshake and the beat boundary it produces
  logic src_hs;
  logic hit_len;
  logic beat_last;

  // count of accepted beats inside the window
  trim_pkg::len_t cnt_q;
  trim_pkg::len_t cnt_next;

  // registered source ready, so the sink ready never reaches the source combinationally
  logic rdy_q;
  logic rdy_d;

  // final is set once the last forwarded beat has been taken from the source
  logic final_q;
  logic final_d;
  logic chopped_q;

  // main output register and the skid behind it
  logic            main_free;
  logic            main_vld_q;
  logic            main_vld_d;
  logic            main_last_q;
  trim_pkg::data_t main_data_q;
  logic            skid_vld_q;
  logic            skid_vld_d;
  logic            skid_last_q;
  trim_pkg::data_t skid_data_q;

  assign src_hs    = src_valid_i & rdy_q;
  assign cnt_next  = cnt_q + 1'b1;
  // limit reached on this beat
  assign hit_len   = (cnt_next == len_i);
  // the length or the source itself ends the forwarded packet
  assign beat_last = hit_len | src_last_i;
  assign final_d   = final_q | (src_hs & beat_last);

  // main register can take a new beat when empty or draining this cycle
  assign main_free = ~main_vld_q | snk_ready_i;

  // occupancy of the two output entries
  always_comb begin
    main_vld_d = main_vld_q;
    skid_vld_d = skid_vld_q;
    if (main_free) begin
      if (skid_vld_q) begin
        // skid moves forward, source is stalled in this cycle
        main_vld_d = 1'b1;
        skid_vld_d = 1'b0;
      end else begin
        main_vld_d = src_hs;
      end
    end else if (src_hs) begin
      // sink stalled with a beat in flight, park it in the skid
      skid_vld_d = 1'b1;
    end
  end

  // take beats only while the window is open, the packet is not finished
  // and the skid will be free next cycle
  assign rdy_d = window_i & ~final_d & ~skid_vld_d;

  // control state, cleared by reset and by the window closing
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdy_q      <= 1'b0;
      main_vld_q <= 1'b0;
      skid_vld_q <= 1'b0;
      final_q    <= 1'b0;
      chopped_q  <= 1'b0;
      cnt_q      <= '0;
    end else if (!window_i) begin
      rdy_q      <= 1'b0;
      main_vld_q <= 1'b0;
      skid_vld_q <= 1'b0;
      final_q    <= 1'b0;
      chopped_q  <= 1'b0;
      cnt_q      <= '0;
    end else begin
      rdy_q      <= rdy_d;
      main_vld_q <= main_vld_d;
      skid_vld_q <= skid_vld_d;
      final_q    <= final_d;
      if (src_hs) begin
        cnt_q <= cnt_next;
        // chopped only when the limit cut the packet before its own last
        if (beat_last) begin
          chopped_q <= hit_len & ~src_last_i;
        end
      end
    end
  end

  // payload of both entries
  always_ff @(posedge clock) begin
    if (main_free) begin
      if (skid_vld_q) begin
        main_data_q <= skid_data_q;
        main_last_q <= skid_last_q;
      end else if (src_hs) begin
        main_data_q <= src_data_i;
        main_last_q <= beat_last;
      end
    end
    if (!main_free && src_hs) begin
      skid_data_q <= src_data_i;
      skid_last_q <= beat_last;
    end
  end

  assign src_ready_o = rdy_q;
  assign snk_valid_o = main_vld_q;
  assign snk_last_o  = main_last_q;
  assign snk_data_o  = main_data_q;

  assign final_o   = final_q;
  assign chopped_o = chopped_q;
  // kept count is the number of beats accepted in this window
  assign kept_o    = cnt_q;

endmodule

//--- logic/trim_drain.sv
module trim_drain (
  input  logic           clock,
  input  logic           rst_n_i,

  // enable from the sequencer
  input  logic           drain_en_i,

  // source side, payload is not needed here
  input  logic           src_valid_i,
  output logic           src_ready_o,
  input  logic           src_last_i,

  // results
  output logic           done_o,
  output trim_pkg::cnt_t dropped_o
);

  // enable of the previous cycle, for the rising edge
  logic en_q;
  logic en_rise;

  // set after the source last has been swallowed
  logic done_q;
  logic src_hs;

  trim_pkg::cnt_t cnt_q;

  assign en_rise = drain_en_i & ~en_q;

  // accept every beat while enabled, until the packet ends
  assign src_ready_o = drain_en_i & ~done_q;
  assign src_hs      = src_valid_i & src_ready_o;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q   <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      en_q <= drain_en_i;

      // done holds until the enable drops
      if (!drain_en_i) begin
        done_q <= 1'b0;
      end else if (src_hs && src_last_i) begin
        done_q <= 1'b1;
      end

      // new tail starts from zero, a beat may already arrive in that cycle
      if (en_rise) begin
        cnt_q <= src_hs ? trim_pkg::cnt_t'(1) : '0;
      end else if (src_hs) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign done_o    = done_q;
  assign dropped_o = cnt_q;

endmodule

//--- logic/trim_pkg.sv
package trim_pkg;

  // width of one stream beat
  localparam int DATA_W = 8;

  // largest length limit a command may carry
  localparam int MAX_LEN = 64;

  // enough bits for 0 up to MAX_LEN
  localparam int LEN_W = $clog2(MAX_LEN + 1);

  // dropped counter is wide so that long tails still count right
  localparam int CNT_W = 16;

  // one beat of stream payload
  typedef logic [DATA_W-1:0] data_t;

  // length limit, or number of beats kept
  typedef logic [LEN_W-1:0] len_t;

  // number of beats drained and thrown away
  typedef logic [CNT_W-1:0] cnt_t;

  // per-packet controller states
  // idle waits for a command, run forwards through the chopper,
  // tail drains the rest of a chopped packet, report offers the status
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    TAIL,
    REPORT
  } seq_state_t;

endpackage

//--- logic/trim_sequencer.sv
module trim_sequencer (
  input  logic           clock,
  input  logic           rst_n_i,

  // command port
  input  logic           cmd_valid_i,
  output logic           cmd_ready_o,
  input  trim_pkg::len_t cmd_len_i,

  // source ready candidates and the routed result
  input  logic           chop_src_ready_i,
  input  logic           drain_src_ready_i,
  output logic           src_ready_o,

  // chopper control and results
  output logic           window_o,
  output trim_pkg::len_t len_o,
  input  logic           final_i,
  input  logic           chopped_i,
  input  trim_pkg::len_t kept_i,

  // sink handshake, watched for the end of the packet
  input  logic           snk_valid_i,
  input  logic           snk_ready_i,
  input  logic           snk_last_i,

  // drain control and results
  output logic           drain_en_o,
  input  logic           drain_done_i,
  input  trim_pkg::cnt_t dropped_i,

  // status port
  output logic           sts_valid_o,
  input  logic           sts_ready_i,
  output trim_pkg::len_t sts_kept_o,
  output trim_pkg::cnt_t sts_dropped_o,
  output logic           sts_chopped_o
);

  trim_pkg::seq_state_t state_q;
  trim_pkg::seq_state_t state_d;

  // registered so that it stays low straight out of reset
  logic cmd_ready_q;
  logic cmd_hs;

  // end of the sink packet
  logic snk_last_hs;
  logic last_seen_q;
  logic sink_done;

  // latched command length and status payload
  trim_pkg::len_t len_q;
  trim_pkg::len_t kept_q;
  trim_pkg::cnt_t dropped_q;
  logic           chopped_q;

  assign cmd_hs      = cmd_valid_i & cmd_ready_q;
  assign snk_last_hs = snk_valid_i & snk_ready_i & snk_last_i;
  // the last beat may leave in this very cycle or already earlier
  assign sink_done   = last_seen_q | snk_last_hs;

  always_comb begin
    state_d = state_q;
    case (state_q)
      trim_pkg::IDLE: begin
        if (cmd_hs) begin
          state_d = trim_pkg::RUN;
        end
      end
      trim_pkg::RUN: begin
        // only a chopped packet has a tail left on the source
        if (final_i && sink_done) begin
          state_d = chopped_i ? trim_pkg::TAIL : trim_pkg::REPORT;
        end
      end
      trim_pkg::TAIL: begin
        if (drain_done_i) begin
          state_d = trim_pkg::REPORT;
        end
      end
      trim_pkg::REPORT: begin
        if (sts_ready_i) begin
          state_d = trim_pkg::IDLE;
        end
      end
      default: begin
        state_d = trim_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= trim_pkg::IDLE;
      cmd_ready_q <= 1'b0;
      last_seen_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      cmd_ready_q <= (state_d == trim_pkg::IDLE);
      // fresh packet, forget the previous last
      if (cmd_hs) begin
        last_seen_q <= 1'b0;
      end else if (state_q == trim_pkg::RUN && snk_last_hs) begin
        last_seen_q <= 1'b1;
      end
    end
  end

  // command length and status payload
  always_ff @(posedge clock) begin
    // zero limit behaves as a limit of one
    if (cmd_hs) begin
      len_q <= (cmd_len_i == '0) ? trim_pkg::len_t'(1) : cmd_len_i;
    end
    // chopper results are final when run ends
    if (state_q == trim_pkg::RUN && state_d != trim_pkg::RUN) begin
      kept_q    <= kept_i;
      chopped_q <= chopped_i;
      dropped_q <= '0;
    end
    if (state_q == trim_pkg::TAIL && drain_done_i) begin
      dropped_q <= dropped_i;
    end
  end

  assign cmd_ready_o = cmd_ready_q;
  assign window_o    = (state_q == trim_pkg::RUN);
  assign len_o       = len_q;
  assign drain_en_o  = (state_q == trim_pkg::TAIL);

  // source belongs to the chopper in run and to the drain in tail
  always_comb begin
    case (state_q)
      trim_pkg::RUN:  src_ready_o = chop_src_ready_i;
      trim_pkg::TAIL: src_ready_o = drain_src_ready_i;
      default:        src_ready_o = 1'b0;
    endcase
  end

  assign sts_valid_o   = (state_q == trim_pkg::REPORT);
  assign sts_kept_o    = kept_q;
  assign sts_dropped_o = dropped_q;
  assign sts_chopped_o = chopped_q;

endmodule

//--- logic/trim_top.sv
module trim_top (
  input  logic            clock,
  input  logic            rst_n_i,

  // command
  input  logic            cmd_valid_i,
  output logic            cmd_ready_o,
  input  trim_pkg::len_t  cmd_len_i,

  // source stream
  input  logic            src_valid_i,
  output logic            src_ready_o,
  input  logic            src_last_i,
  input  trim_pkg::data_t src_data_i,

  // sink stream
  output logic            snk_valid_o,
  input  logic            snk_ready_i,
  output logic            snk_last_o,
  output trim_pkg::data_t snk_data_o,

  // status
  output logic            sts_valid_o,
  input  logic            sts_ready_i,
  output trim_pkg::len_t  sts_kept_o,
  output trim_pkg::cnt_t  sts_dropped_o,
  output logic            sts_chopped_o
);

  // sequencer to chopper
  logic           window;
  trim_pkg::len_t len;

  // chopper back to sequencer
  logic           chop_src_ready;
  logic           chop_final;
  logic           chop_chopped;
  trim_pkg::len_t chop_kept;

  // sequencer and drain
  logic           drain_en;
  logic           drain_src_ready;
  logic           drain_done;
  trim_pkg::cnt_t drain_dropped;

  // source payload goes to the chopper, valid and last to both
  trim_chop u_chop (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .window_i    (window),
    .len_i       (len),
    .src_valid_i (src_valid_i),
    .src_ready_o (chop_src_ready),
    .src_last_i  (src_last_i),
    .src_data_i  (src_data_i),
    .snk_valid_o (snk_valid_o),
    .snk_ready_i (snk_ready_i),
    .snk_last_o  (snk_last_o),
    .snk_data_o  (snk_data_o),
    .final_o     (chop_final),
    .chopped_o   (chop_chopped),
    .kept_o      (chop_kept)
  );

  trim_drain u_drain (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .drain_en_i  (drain_en),
    .src_valid_i (src_valid_i),
    .src_ready_o (drain_src_ready),
    .src_last_i  (src_last_i),
    .done_o      (drain_done),
    .dropped_o   (drain_dropped)
  );

  // the sequencer alone drives the source ready
  trim_sequencer u_seq (
    .clock             (clock),
    .rst_n_i           (rst_n_i),
    .cmd_valid_i       (cmd_valid_i),
    .cmd_ready_o       (cmd_ready_o),
    .cmd_len_i         (cmd_len_i),
    .chop_src_ready_i  (chop_src_ready),
    .drain_src_ready_i (drain_src_ready),
    .src_ready_o       (src_ready_o),
    .window_o          (window),
    .len_o             (len),
    .final_i           (chop_final),
    .chopped_i         (chop_chopped),
    .kept_i            (chop_kept),
    .snk_valid_i       (snk_valid_o),
    .snk_ready_i       (snk_ready_i),
    .snk_last_i        (snk_last_o),
    .drain_en_o        (drain_en),
    .drain_done_i      (drain_done),
    .dropped_i         (drain_dropped),
    .sts_valid_o       (sts_valid_o),
    .sts_ready_i       (sts_ready_i),
    .sts_kept_o        (sts_kept_o),
    .sts_dropped_o     (sts_dropped_o),
    .sts_chopped_o     (sts_chopped_o)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the packet trimmer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation failed"
PASS_MSG="Simulation completed successfully"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module trim_tb -f build.f -o Vtrim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtrim_tb +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "result: FAIL"
  exit 1
fi
if [ $sim_status -ne 0 ] || ! grep -q "$PASS_MSG" "$LOG"; then
  echo "result: FAIL, run ended early"
  exit 1
fi
echo "result: PASS"
exit 0

//--- verification/trim_assert.sv
module trim_assert (
  input logic            clock,
  input logic            rst_n_i,
  input logic            cmd_ready_i,
  input logic            src_ready_i,
  input logic            snk_valid_i,
  input logic            snk_ready_i,
  input logic            snk_last_i,
  input trim_pkg::data_t snk_data_i,
  input logic            sts_valid_i,
  input logic            sts_ready_i,
  input trim_pkg::len_t  sts_kept_i,
  input trim_pkg::cnt_t  sts_dropped_i,
  input logic            sts_chopped_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // failures seen so far, read back by the testbench
  int fail_cnt = 0;

  // stalled sink beat keeps valid, data and last
  snk_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    (snk_valid_i && !snk_ready_i) |=> (snk_valid_i && $stable(snk_data_i) && $stable(snk_last_i)))
    else begin
      fail_cnt++;
      $error("sink beat changed while stalled");
    end

  // status word keeps valid and payload until taken
  sts_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    (sts_valid_i && !sts_ready_i) |=> (sts_valid_i && $stable(sts_kept_i)
      && $stable(sts_dropped_i) && $stable(sts_chopped_i)))
    else begin
      fail_cnt++;
      $error("status changed while stalled");
    end

  cmd_sts_excl: assert property (@(posedge clock) disable iff (!rst_n_i)
    !(cmd_ready_i && sts_valid_i))
    else begin
      fail_cnt++;
      $error("command ready and status valid high together");
    end

  // idle shows as cmd ready, report as status valid
  src_quiet: assert property (@(posedge clock) disable iff (!rst_n_i)
    (cmd_ready_i || sts_valid_i) |-> !src_ready_i)
    else begin
      fail_cnt++;
      $error("source ready high outside run or tail");
    end

endmodule

bind trim_top trim_assert u_assert (
  .clock         (clock),
  .rst_n_i       (rst_n_i),
  .cmd_ready_i   (cmd_ready_o),
  .src_ready_i   (src_ready_o),
  .snk_valid_i   (snk_valid_o),
  .snk_ready_i   (snk_ready_i),
  .snk_last_i    (snk_last_o),
  .snk_data_i    (snk_data_o),
  .sts_valid_i   (sts_valid_o),
  .sts_ready_i   (sts_ready_i),
  .sts_kept_i    (sts_kept_o),
  .sts_dropped_i (sts_dropped_o),
  .sts_chopped_i (sts_chopped_o)
);

//--- verification/trim_tb.sv
module trim_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS   = 10;
  localparam int MAX_BEATS   = 80;
  // each row gets a generous slice of cycles, plus slack for reset
  localparam int CYCLE_LIMIT = NUM_TESTS * 40 + 100;

  logic            clock;
  logic            rst_n_i;
  logic            cmd_valid_i;
  logic            cmd_ready_o;
  trim_pkg::len_t  cmd_len_i;
  logic            src_valid_i;
  logic            src_ready_o;
  logic            src_last_i;
  trim_pkg::data_t src_data_i;
  logic            snk_valid_o;
  logic            snk_ready_i;
  logic            snk_last_o;
  trim_pkg::data_t snk_data_o;
  logic            sts_valid_o;
  logic            sts_ready_i;
  trim_pkg::len_t  sts_kept_o;
  trim_pkg::cnt_t  sts_dropped_o;
  logic            sts_chopped_o;

  // stimulus columns of the table
  string          row_name  [NUM_TESTS];
  trim_pkg::len_t row_lim   [NUM_TESTS];
  int             row_beats [NUM_TESTS];
  int             row_gap   [NUM_TESTS];
  int             row_stall [NUM_TESTS];
  // expected columns, filled in from the trimming rules
  trim_pkg::len_t row_kept  [NUM_TESTS];
  trim_pkg::cnt_t row_drop  [NUM_TESTS];
  logic           row_chop  [NUM_TESTS];

  // payload of the packet currently sent
  trim_pkg::data_t pkt [MAX_BEATS];

  integer seed = 32'h5511;
  int     cycle_cnt;

  trim_top dut (.*);

  initial clock = 1'b0;
  always #2 clock = ~clock;

  task automatic check_data(input string what, input trim_pkg::data_t exp,
                            input trim_pkg::data_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %0h, actual %0h", what, exp, act);
      $display("Simulation failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_len(input string what, input trim_pkg::len_t exp,
                           input trim_pkg::len_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %0d, actual %0d", what, exp, act);
      $display("Simulation failed");
      $fatal(1, "length mismatch");
    end
  endtask

  task automatic check_cnt(input string what, input trim_pkg::cnt_t exp,
                           input trim_pkg::cnt_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %0d, actual %0d", what, exp, act);
      $display("Simulation failed");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %0b, actual %0b", what, exp, act);
      $display("Simulation failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  // percent draw for gaps and stalls
  function automatic int rand_pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  task automatic set_row(input int idx, input string name, input int lim, input int beats,
                         input int gap, input int stall);
    int eff;
    int kept;
    // a zero limit behaves as one
    eff  = (lim == 0) ? 1 : lim;
    kept = (beats < eff) ? beats : eff;
    row_name[idx]  = name;
    row_lim[idx]   = trim_pkg::len_t'(lim);
    row_beats[idx] = beats;
    row_gap[idx]   = gap;
    row_stall[idx] = stall;
    row_kept[idx]  = trim_pkg::len_t'(kept);
    row_drop[idx]  = trim_pkg::cnt_t'(beats - kept);
    row_chop[idx]  = (beats > eff);
  endtask

  task automatic load_table();
    set_row(0, "short_pass", 8, 5, 0, 0);
    set_row(1, "long_chop", 6, 12, 0, 0);
    set_row(2, "exact_len", 7, 7, 0, 0);
    set_row(3, "random_chop", 10, 16, 30, 30);
    set_row(4, "random_pass", 20, 14, 25, 40);
    // back to back limits of one, max and zero
    set_row(5, "limit_one", 1, 4, 0, 0);
    set_row(6, "limit_max", trim_pkg::MAX_LEN, 70, 0, 0);
    set_row(7, "limit_zero", 0, 3, 0, 0);
    set_row(8, "single_beat", 5, 1, 0, 0);
    set_row(9, "max_whole", trim_pkg::MAX_LEN, 40, 10, 10);
  endtask

  task automatic run_row(input int idx);
    int    si;
    int    ki;
    int    beats;
    bit    cmd_done;
    bit    sts_done;
    bit    src_sent;
    string name;
    name  = row_name[idx];
    beats = row_beats[idx];
    for (int i = 0; i < beats; i++) begin
      pkt[i] = trim_pkg::data_t'($random(seed));
    end
    si       = 0;
    ki       = 0;
    cmd_done = 1'b0;
    sts_done = 1'b0;
    src_sent = 1'b0;
    while (!sts_done) begin
      @(posedge clock);
      #0.5;
      cmd_valid_i = !cmd_done;
      cmd_len_i   = row_lim[idx];
      // a pending source beat holds until it is taken
      if (src_sent || !src_valid_i) begin
        src_valid_i = (si < beats) && (rand_pct() >= row_gap[idx]);
        src_data_i  = (si < beats) ? pkt[si] : '0;
        src_last_i  = (si == beats - 1);
      end
      src_sent    = 1'b0;
      snk_ready_i = (rand_pct() >= row_stall[idx]);
      sts_ready_i = (rand_pct() >= row_stall[idx]);
      // handshakes are judged at the falling edge, ahead of the rising one
      @(negedge clock);
      if (cmd_valid_i && cmd_ready_o) begin
        cmd_done = 1'b1;
      end
      if (src_valid_i && src_ready_o) begin
        si++;
        src_sent = 1'b1;
      end
      if (snk_valid_o && snk_ready_i) begin
        if (ki >= int'(row_kept[idx])) begin
          $display("%s: sink delivered more beats than the limit allows", name);
          $display("Simulation failed");
          $fatal(1, "extra sink beat");
        end
        check_data($sformatf("%s beat %0d data", name, ki), pkt[ki], snk_data_o);
        check_flag($sformatf("%s beat %0d last", name, ki),
                   ki == int'(row_kept[idx]) - 1, snk_last_o);
        ki++;
      end
      if (sts_valid_o && sts_ready_i) begin
        check_len({name, " kept"}, row_kept[idx], sts_kept_o);
        check_cnt({name, " dropped"}, row_drop[idx], sts_dropped_o);
        check_flag({name, " chopped"}, row_chop[idx], sts_chopped_o);
        check_len({name, " sink beats"}, row_kept[idx], trim_pkg::len_t'(ki));
        check_cnt({name, " source beats"}, trim_pkg::cnt_t'(beats), trim_pkg::cnt_t'(si));
        sts_done = 1'b1;
      end
    end
  endtask

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the table did not finish", cycle_cnt);
    $display("Simulation failed");
    $fatal(1, "cycle limit reached");
  end

  // a protocol assertion that fired ends the run on the next falling edge
  always @(negedge clock) begin
    if (dut.u_assert.fail_cnt != 0) begin
      $display("protocol assertion failed near cycle %0d", cycle_cnt);
      $display("Simulation failed");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    rst_n_i     = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_len_i   = '0;
    src_valid_i = 1'b0;
    src_last_i  = 1'b0;
    src_data_i  = '0;
    snk_ready_i = 1'b0;
    sts_ready_i = 1'b0;
    load_table();
    repeat (4) @(posedge clock);
    #0.5;
    // outputs quiet while reset is held
    check_flag("reset cmd_ready", 1'b0, cmd_ready_o);
    check_flag("reset src_ready", 1'b0, src_ready_o);
    check_flag("reset snk_valid", 1'b0, snk_valid_o);
    check_flag("reset sts_valid", 1'b0, sts_valid_o);
    rst_n_i = 1'b1;
    for (int idx = 0; idx < NUM_TESTS; idx++) begin
      run_row(idx);
    end
    @(posedge clock);
    if (dut.u_assert.fail_cnt != 0) begin
      $display("protocol assertions failed %0d times", dut.u_assert.fail_cnt);
      $display("Simulation failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule
